// File: hdl/glue_macros.svh
`ifndef GLUE_MACROS_SVH
`define GLUE_MACROS_SVH

`define GLUE_IOCTL_AW 25
`define GLUE_BG_BASE  'hE000 // graphics region start in the download
`define GLUE_BG_SIZE  'h8000
`define GLUE_DAC_BITS 12

// ps/2 set 2 scancodes
`define GLUE_KEY_UP    8'h75
`define GLUE_KEY_DOWN  8'h72
`define GLUE_KEY_LEFT  8'h6B
`define GLUE_KEY_RIGHT 8'h74
`define GLUE_KEY_FIRE  8'h29 // space
`define GLUE_KEY_COIN  8'h76 // esc
`define GLUE_KEY_P1    8'h05 // f1
`define GLUE_KEY_P2    8'h06 // f2

`endif

// File: hdl/glue_pkg.sv
`default_nettype none

package glue_pkg;

	// sdram write port fields
	typedef logic [22:0] port_addr1_t; // 16-bit word address, program image
	typedef logic [13:0] port_addr2_t; // 32-bit word address, graphics
	typedef logic [1:0] byte_sel_t;    // bit 1 = high lane
	typedef logic [15:0] port_data_t;

	// key levels, one per mapped scancode
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic coin;
		logic one_player;
		logic two_players;
	} buttons_t;

	// one switch byte as the core sees it
	typedef logic [7:0] switch_word_t;

endpackage

`default_nettype wire

// File: hdl/rom_port_if.sv
`timescale 1ns/1ps
`default_nettype none

// one sdram write port, toggle requested
interface rom_port_if;

	logic req; // each level change is one write
	glue_pkg::port_addr1_t a;
	glue_pkg::byte_sel_t ds;
	logic we;
	glue_pkg::port_data_t d;

	modport loader (
		output req,
		output a,
		output ds,
		output we,
		output d
	);

	modport mem (
		input req,
		input a,
		input ds,
		input we,
		input d
	);

endinterface

`default_nettype wire

// File: hdl/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "glue_macros.svh"

module rom_loader (
	input  logic clock_48,
	input  logic reset,
	input  logic ioctl_download,
	input  logic ioctl_wr,
	input  logic [`GLUE_IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	rom_port_if.loader port1,
	rom_port_if.loader port2
);

	logic wr_last;
	logic wr_rise;
	logic [`GLUE_IOCTL_AW-1:0] bg_offset;
	logic in_bg;
	glue_pkg::port_addr2_t bg_word;

	assign wr_rise = ioctl_wr & ~wr_last;
	assign bg_offset = ioctl_addr - `GLUE_IOCTL_AW'(`GLUE_BG_BASE);
	assign in_bg = bg_offset < `GLUE_IOCTL_AW'(`GLUE_BG_SIZE); // below base wraps high
	// two graphics roms side by side in one 32-bit word
	assign bg_word = {bg_offset[12:0], bg_offset[14]};

	always_ff @(posedge clock_48) begin
		if (reset) begin
			wr_last <= 1'b0;
			port1.req <= 1'b0;
			port1.a <= '0;
			port1.ds <= '0;
			port1.we <= 1'b0;
			port1.d <= '0;
			port2.req <= 1'b0;
			port2.a <= '0;
			port2.ds <= '0;
			port2.we <= 1'b0;
			port2.d <= '0;
		end else begin
			wr_last <= ioctl_wr;
			port1.we <= ioctl_download;
			port2.we <= ioctl_download;
			if (ioctl_download && wr_rise) begin
				port1.req <= ~port1.req;
				port1.a <= ioctl_addr[23:1];
				port1.ds <= {ioctl_addr[0], ~ioctl_addr[0]};
				port1.d <= {ioctl_dout, ioctl_dout};
				if (in_bg) begin
					port2.req <= ~port2.req;
					port2.a <= glue_pkg::port_addr1_t'(bg_word);
					port2.ds <= {bg_offset[13], ~bg_offset[13]};
					port2.d <= {ioctl_dout, ioctl_dout};
				end
			end
		end
	end

	a_no_req_idle: assert property (@(posedge clock_48) disable iff (reset)
		!ioctl_download |=> $stable(port1.req) && $stable(port2.req))
		else $error("sdram request toggled outside a download");

	a_port2_with_port1: assert property (@(posedge clock_48) disable iff (reset)
		$changed(port2.req) |-> $changed(port1.req))
		else $error("port2 request without port1 request");

endmodule

`default_nettype wire

// File: hdl/core_reset.sv
`timescale 1ns/1ps
`default_nettype none

module core_reset (
	input  logic clock_48,
	input  logic reset,
	input  logic ioctl_download,
	input  logic [31:0] status,
	input  logic [1:0] buttons,
	output logic core_reset
);

	logic download_d;
	logic rom_loaded; // sticky until board reset

	always_ff @(posedge clock_48) begin
		if (reset) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_d <= ioctl_download;
			if (download_d && !ioctl_download) rom_loaded <= 1'b1; // falling edge
			// menu reset, osd reset entry, board button
			core_reset <= status[0] | status[6] | buttons[1] | ~rom_loaded;
		end
	end

	a_reset_request: assert property (@(posedge clock_48) disable iff (reset)
		(status[0] || status[6] || buttons[1]) |=> core_reset)
		else $error("core reset missed a request");

endmodule

`default_nettype wire

// File: hdl/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "glue_macros.svh"

module key_decoder (
	input  logic clock_48,
	input  logic reset,
	input  logic key_strobe,
	input  logic key_pressed,
	input  logic [7:0] key_code,
	output glue_pkg::buttons_t keys
);

	logic strobe_last;
	logic key_event;

	assign key_event = key_strobe != strobe_last; // strobe toggles per event

	always_ff @(posedge clock_48) begin
		if (reset) begin
			strobe_last <= 1'b0;
			keys <= '0;
		end else begin
			strobe_last <= key_strobe;
			if (key_event) begin
				case (key_code)
					`GLUE_KEY_UP:    keys.up <= key_pressed;
					`GLUE_KEY_DOWN:  keys.down <= key_pressed;
					`GLUE_KEY_LEFT:  keys.left <= key_pressed;
					`GLUE_KEY_RIGHT: keys.right <= key_pressed;
					`GLUE_KEY_FIRE:  keys.fire <= key_pressed;
					`GLUE_KEY_COIN:  keys.coin <= key_pressed;
					`GLUE_KEY_P1:    keys.one_player <= key_pressed;
					`GLUE_KEY_P2:    keys.two_players <= key_pressed;
					default: ; // other keys ignored
				endcase
			end
		end
	end

	a_keys_on_event: assert property (@(posedge clock_48) disable iff (reset)
		$changed(keys) |-> $past(key_event))
		else $error("key level changed without a strobe");

endmodule

`default_nettype wire

// File: hdl/control_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  glue_pkg::buttons_t keys,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic rotate,
	output glue_pkg::switch_word_t p1_sw,
	output glue_pkg::switch_word_t p2_sw,
	output glue_pkg::switch_word_t s_sys
);

	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic fire;
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;

	// joystick bits 0..4 are right, left, down, up, fire
	assign src_right = keys.right | joystick_0[0] | joystick_1[0];
	assign src_left = keys.left | joystick_0[1] | joystick_1[1];
	assign src_down = keys.down | joystick_0[2] | joystick_1[2];
	assign src_up = keys.up | joystick_0[3] | joystick_1[3];
	assign fire = keys.fire | joystick_0[4] | joystick_1[4];

	// screen turned a quarter for vertical cabinets
	assign m_up = rotate ? src_left : src_up;
	assign m_down = rotate ? src_right : src_down;
	assign m_left = rotate ? src_down : src_left;
	assign m_right = rotate ? src_up : src_right;

	assign p1_sw = {3'b000, fire, m_down, m_up, m_left, m_right};
	assign p2_sw = p1_sw; // both players share the controls

	assign s_sys = {4'b1111, keys.two_players, keys.one_player, 1'b1, keys.coin};

endmodule

`default_nettype wire

// File: hdl/sigma_delta_dac.sv
`timescale 1ns/1ps
`default_nettype none

`include "glue_macros.svh"

// first order, carry out is the bitstream
module sigma_delta_dac #(
	parameter int bits = `GLUE_DAC_BITS
) (
	input  logic clock_48,
	input  logic reset,
	input  logic [bits-1:0] sample,
	output logic pdm
);

	logic [bits:0] acc; // top bit holds the last carry

	always_ff @(posedge clock_48) begin
		if (reset) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[bits-1:0]} + {1'b0, sample};
		end
	end

	assign pdm = acc[bits];

endmodule

`default_nettype wire

// File: hdl/bombjack_glue.sv
`timescale 1ns/1ps
`default_nettype none

`include "glue_macros.svh"

module bombjack_glue (
	input  logic clock_48,
	input  logic reset,
	input  logic ioctl_download,
	input  logic ioctl_wr,
	input  logic [`GLUE_IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	input  logic [31:0] status,
	input  logic [1:0] buttons,
	input  logic key_strobe,
	input  logic key_pressed,
	input  logic [7:0] key_code,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic [`GLUE_DAC_BITS-1:0] audio_l,
	input  logic [`GLUE_DAC_BITS-1:0] audio_r,
	output logic port1_req,
	output glue_pkg::port_addr1_t port1_a,
	output glue_pkg::byte_sel_t port1_ds,
	output logic port1_we,
	output glue_pkg::port_data_t port1_d,
	output logic port2_req,
	output glue_pkg::port_addr2_t port2_a,
	output glue_pkg::byte_sel_t port2_ds,
	output logic port2_we,
	output glue_pkg::port_data_t port2_d,
	output logic core_reset,
	output glue_pkg::switch_word_t p1_sw,
	output glue_pkg::switch_word_t p2_sw,
	output glue_pkg::switch_word_t s_sys,
	output logic audio_l_out,
	output logic audio_r_out
);

	rom_port_if port1_bus ();
	rom_port_if port2_bus ();

	glue_pkg::buttons_t keys;

	rom_loader loader (
		.clock_48(clock_48),
		.reset(reset),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.port1(port1_bus.loader),
		.port2(port2_bus.loader)
	);

	assign port1_req = port1_bus.req;
	assign port1_a = port1_bus.a;
	assign port1_ds = port1_bus.ds;
	assign port1_we = port1_bus.we;
	assign port1_d = port1_bus.d;
	assign port2_req = port2_bus.req;
	assign port2_a = glue_pkg::port_addr2_t'(port2_bus.a); // graphics port is narrower
	assign port2_ds = port2_bus.ds;
	assign port2_we = port2_bus.we;
	assign port2_d = port2_bus.d;

	core_reset reset_ctl (
		.clock_48(clock_48),
		.reset(reset),
		.ioctl_download(ioctl_download),
		.status(status),
		.buttons(buttons),
		.core_reset(core_reset)
	);

	key_decoder keyboard (
		.clock_48(clock_48),
		.reset(reset),
		.key_strobe(key_strobe),
		.key_pressed(key_pressed),
		.key_code(key_code),
		.keys(keys)
	);

	control_mapper controls (
		.keys(keys),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.rotate(status[2]), // osd rotate option
		.p1_sw(p1_sw),
		.p2_sw(p2_sw),
		.s_sys(s_sys)
	);

	sigma_delta_dac #(.bits(`GLUE_DAC_BITS)) dac_l (
		.clock_48(clock_48),
		.reset(reset),
		.sample(audio_l),
		.pdm(audio_l_out)
	);

	sigma_delta_dac #(.bits(`GLUE_DAC_BITS)) dac_r (
		.clock_48(clock_48),
		.reset(reset),
		.sample(audio_r),
		.pdm(audio_r_out)
	);

endmodule

`default_nettype wire

// File: testbench/tb_bombjack_glue.sv
`timescale 1ns/1ps
`default_nettype none

`include "glue_macros.svh"

module tb_bombjack_glue;

	localparam int reset_len = 10;
	localparam int download_len = 64 * 2 + 12;
	localparam int request_len = 3 * 3 + 4;
	localparam int key_len = 2 * 8 + 8;
	localparam int joy_len = 32 + 4;
	localparam int dac_len = 2 * 2 * 4096 + 4;
	localparam int watchdog_cycles =
		2 * (reset_len + download_len + request_len + key_len + joy_len + dac_len);
	localparam logic [`GLUE_IOCTL_AW-1:0] bg_base = `GLUE_IOCTL_AW'(`GLUE_BG_BASE);
	localparam logic [`GLUE_IOCTL_AW-1:0] bg_end = bg_base + `GLUE_IOCTL_AW'(`GLUE_BG_SIZE);
	localparam logic [7:0] key_list [8] = '{`GLUE_KEY_UP, `GLUE_KEY_DOWN, `GLUE_KEY_LEFT,
		`GLUE_KEY_RIGHT, `GLUE_KEY_FIRE, `GLUE_KEY_COIN, `GLUE_KEY_P1, `GLUE_KEY_P2};

	logic clock_48;
	logic reset;
	logic ioctl_download;
	logic ioctl_wr;
	logic [`GLUE_IOCTL_AW-1:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic [31:0] status;
	logic [1:0] buttons;
	logic key_strobe;
	logic key_pressed;
	logic [7:0] key_code;
	logic [7:0] joystick_0;
	logic [7:0] joystick_1;
	logic [`GLUE_DAC_BITS-1:0] audio_l;
	logic [`GLUE_DAC_BITS-1:0] audio_r;
	logic port1_req;
	glue_pkg::port_addr1_t port1_a;
	glue_pkg::byte_sel_t port1_ds;
	logic port1_we;
	glue_pkg::port_data_t port1_d;
	logic port2_req;
	glue_pkg::port_addr2_t port2_a;
	glue_pkg::byte_sel_t port2_ds;
	logic port2_we;
	glue_pkg::port_data_t port2_d;
	logic core_reset;
	glue_pkg::switch_word_t p1_sw;
	glue_pkg::switch_word_t p2_sw;
	glue_pkg::switch_word_t s_sys;
	logic audio_l_out;
	logic audio_r_out;

	logic [31:0] lcg_state;
	logic req1_model;
	logic req2_model;
	glue_pkg::buttons_t key_model;

	bombjack_glue dut0 (
		.clock_48(clock_48), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.status(status), .buttons(buttons),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.audio_l(audio_l), .audio_r(audio_r),
		.port1_req(port1_req), .port1_a(port1_a), .port1_ds(port1_ds),
		.port1_we(port1_we), .port1_d(port1_d),
		.port2_req(port2_req), .port2_a(port2_a), .port2_ds(port2_ds),
		.port2_we(port2_we), .port2_d(port2_d),
		.core_reset(core_reset), .p1_sw(p1_sw), .p2_sw(p2_sw), .s_sys(s_sys),
		.audio_l_out(audio_l_out), .audio_r_out(audio_r_out)
	);

	always #50 clock_48 = ~clock_48;

	task automatic value_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic run_failed(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [31:0] lcg_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic glue_pkg::buttons_t key_update(input glue_pkg::buttons_t k,
		input logic [7:0] code, input logic pressed);
		glue_pkg::buttons_t n;
		n = k;
		case (code)
			`GLUE_KEY_UP: n.up = pressed;
			`GLUE_KEY_DOWN: n.down = pressed;
			`GLUE_KEY_LEFT: n.left = pressed;
			`GLUE_KEY_RIGHT: n.right = pressed;
			`GLUE_KEY_FIRE: n.fire = pressed;
			`GLUE_KEY_COIN: n.coin = pressed;
			`GLUE_KEY_P1: n.one_player = pressed;
			`GLUE_KEY_P2: n.two_players = pressed;
			default: ;
		endcase
		return n;
	endfunction

	function automatic logic [7:0] expected_player(input glue_pkg::buttons_t k,
		input logic [7:0] j0, input logic [7:0] j1, input logic rot);
		logic r;
		logic l;
		logic d;
		logic u;
		logic f;
		r = k.right | j0[0] | j1[0];
		l = k.left | j0[1] | j1[1];
		d = k.down | j0[2] | j1[2];
		u = k.up | j0[3] | j1[3];
		f = k.fire | j0[4] | j1[4];
		if (rot)
			return {3'b000, f, r, l, d, u}; // quarter turn
		return {3'b000, f, d, u, l, r};
	endfunction

	task automatic check_switches();
		logic [7:0] exp_p;
		logic [7:0] exp_s;
		exp_p = expected_player(key_model, joystick_0, joystick_1, status[2]);
		exp_s = {4'hF, key_model.two_players, key_model.one_player, 1'b1, key_model.coin};
		assert (p1_sw == exp_p) else value_mismatch("p1_sw", 32'(p1_sw), 32'(exp_p));
		assert (p2_sw == exp_p) else value_mismatch("p2_sw", 32'(p2_sw), 32'(exp_p));
		assert (s_sys == exp_s) else value_mismatch("s_sys", 32'(s_sys), 32'(exp_s));
	endtask

	task automatic download_write(input logic [`GLUE_IOCTL_AW-1:0] addr,
		input logic [7:0] data);
		logic [`GLUE_IOCTL_AW-1:0] off;
		logic hit;
		off = addr - bg_base;
		hit = addr >= bg_base && addr < bg_end;
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(posedge clock_48);
		#1;
		req1_model = ~req1_model;
		if (hit) req2_model = ~req2_model;
		assert (port1_req == req1_model)
			else value_mismatch("port1_req", 32'(port1_req), 32'(req1_model));
		assert (port1_a == addr[23:1])
			else value_mismatch("port1_a", 32'(port1_a), 32'(addr[23:1]));
		assert (port1_ds == (addr[0] ? 2'b10 : 2'b01))
			else value_mismatch("port1_ds", 32'(port1_ds), 32'(addr[0] ? 2'b10 : 2'b01));
		assert (port1_d == {data, data})
			else value_mismatch("port1_d", 32'(port1_d), 32'({data, data}));
		assert (port1_we && port2_we) else run_failed("write enable low during a download");
		assert (port2_req == req2_model)
			else value_mismatch("port2_req", 32'(port2_req), 32'(req2_model));
		if (hit) begin
			assert (port2_a == {off[12:0], off[14]})
				else value_mismatch("port2_a", 32'(port2_a), 32'({off[12:0], off[14]}));
			assert (port2_ds == (off[13] ? 2'b10 : 2'b01))
				else value_mismatch("port2_ds", 32'(port2_ds), 32'(off[13] ? 2'b10 : 2'b01));
			assert (port2_d == {data, data})
				else value_mismatch("port2_d", 32'(port2_d), 32'({data, data}));
		end
		#9;
		ioctl_wr = 1'b0;
		@(posedge clock_48);
		#10;
	endtask

	task automatic reset_request(input logic [31:0] st, input logic [1:0] bt,
		input string name);
		status = st;
		buttons = bt;
		@(posedge clock_48);
		#1;
		assert (core_reset) else run_failed({"core reset not raised by ", name});
		#9;
		status = 32'h0;
		buttons = 2'b00;
		@(posedge clock_48);
		@(posedge clock_48);
		#1;
		assert (!core_reset) else run_failed({"core reset stuck high after ", name});
		#9;
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		key_code = code;
		key_pressed = pressed;
		key_strobe = ~key_strobe; // one event per level change
		@(posedge clock_48);
		#1;
		key_model = key_update(key_model, code, pressed);
		check_switches();
		#9;
	endtask

	task automatic dac_run(input logic [`GLUE_DAC_BITS-1:0] l,
		input logic [`GLUE_DAC_BITS-1:0] r);
		int ones_l;
		int ones_r;
		audio_l = l;
		audio_r = r;
		repeat (4096) @(posedge clock_48); // settling window
		ones_l = 0;
		ones_r = 0;
		repeat (4096) begin
			@(posedge clock_48);
			#1;
			if (audio_l_out) ones_l++;
			if (audio_r_out) ones_r++;
		end
		assert (ones_l == int'(l)) else value_mismatch("audio_l_out ones", 32'(ones_l), 32'(l));
		assert (ones_r == int'(r)) else value_mismatch("audio_r_out ones", 32'(ones_r), 32'(r));
		#9;
	endtask

	a_idle_stable: assert property (@(posedge clock_48) disable iff (reset)
		!ioctl_download |=> $stable(port1_req) && $stable(port2_req))
		else run_failed("sdram request toggled while no download was active");

	a_port2_pairs: assert property (@(posedge clock_48) disable iff (reset)
		$changed(port2_req) |-> $changed(port1_req))
		else run_failed("port2 request toggled without a port1 request");

	a_hold_in_download: assert property (@(posedge clock_48) disable iff (reset)
		ioctl_download |-> core_reset)
		else run_failed("core reset dropped during the download");

	a_request_reset: assert property (@(posedge clock_48) disable iff (reset)
		(status[0] || status[6] || buttons[1]) |=> core_reset)
		else run_failed("core reset did not follow a reset request");

	initial begin
		repeat (watchdog_cycles) @(posedge clock_48);
		run_failed("watchdog timeout, the tests did not finish in time");
	end

	initial begin
		logic [31:0] r;
		logic [`GLUE_IOCTL_AW-1:0] addr;
		logic fell;
		clock_48 = 1'b0;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'h00;
		status = 32'h0;
		buttons = 2'b00;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = 8'h00;
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		audio_l = '0;
		audio_r = '0;
		lcg_state = 32'd50;
		req1_model = 1'b0;
		req2_model = 1'b0;
		key_model = '0;
		repeat (8) @(posedge clock_48);
		#10;
		reset = 1'b0;
		@(posedge clock_48);
		#1;
		assert (!port1_req && !port2_req) else run_failed("request set after reset");
		assert (!audio_l_out && !audio_r_out) else run_failed("dac output set after reset");
		assert (core_reset) else run_failed("core reset low after reset");
		check_switches(); // p1_sw 00, s_sys f2
		#9;

		ioctl_download = 1'b1;
		@(posedge clock_48);
		#10;
		for (int i = 0; i < 64; i++) begin
			r = lcg_rand();
			if (i % 2 == 0) begin
				addr = bg_base + `GLUE_IOCTL_AW'(r[30:16]);
			end else begin
				addr = r[31:7];
				if (addr >= bg_base && addr < bg_end) addr[20] = ~addr[20];
			end
			download_write(addr, r[23:16]);
		end
		ioctl_download = 1'b0;
		fell = 1'b0;
		repeat (2) begin
			@(posedge clock_48);
			#1;
			if (!core_reset) fell = 1'b1;
		end
		assert (fell) else run_failed("core reset still high two cycles after the download");
		#9;

		// write strobe outside a download
		ioctl_wr = 1'b1;
		@(posedge clock_48);
		#1;
		assert (port1_req == req1_model && port2_req == req2_model)
			else run_failed("write outside a download issued a request");
		assert (!port1_we && !port2_we) else run_failed("write enable high after the download");
		#9;
		ioctl_wr = 1'b0;

		reset_request(32'h0000_0001, 2'b00, "status bit 0");
		reset_request(32'h0000_0040, 2'b00, "status bit 6");
		reset_request(32'h0000_0000, 2'b10, "buttons bit 1");

		foreach (key_list[k]) send_key(key_list[k], 1'b1);
		send_key(8'h1C, 1'b0); // unmapped
		foreach (key_list[k]) send_key(key_list[k], 1'b0);

		send_key(`GLUE_KEY_LEFT, 1'b1);
		for (int i = 0; i < 32; i++) begin
			r = lcg_rand();
			joystick_0 = r[31:24];
			joystick_1 = r[23:16];
			status = (i >= 16) ? 32'h0000_0004 : 32'h0; // rotate option
			@(posedge clock_48);
			#1;
			check_switches();
			#9;
		end
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		status = 32'h0;
		send_key(`GLUE_KEY_LEFT, 1'b0);

		r = lcg_rand();
		dac_run(r[27:16], r[30:19]);
		dac_run(12'hFFF, 12'h001);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: bombjack_glue.f
+incdir+hdl
hdl/glue_pkg.sv
hdl/rom_port_if.sv
hdl/rom_loader.sv
hdl/core_reset.sv
hdl/key_decoder.sv
hdl/control_mapper.sv
hdl/sigma_delta_dac.sv
hdl/bombjack_glue.sv
testbench/tb_bombjack_glue.sv

// File: Makefile
.PHONY: all lint clean

all: obj_dir/sim
	./obj_dir/sim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

obj_dir/sim: bombjack_glue.f hdl/*.sv hdl/*.svh testbench/*.sv
	verilator --binary --timing --assert -f bombjack_glue.f \
		--top-module tb_bombjack_glue -o sim

lint:
	verilator --lint-only --timing --assert -f bombjack_glue.f \
		--top-module tb_bombjack_glue

clean:
	rm -rf obj_dir sim.log
